// ==== hdl/debayer_consts.svh ====
`ifndef DEBAYER_CONSTS_SVH
`define DEBAYER_CONSTS_SVH

// ------------------------------------------------------------
// sample and line geometry
// ------------------------------------------------------------

// raw sample width
`define DEBAYER_PIX_W 8

// line buffer depth, max active samples per line
`define DEBAYER_LINE_MAX 1024

// column and row counter width
`define DEBAYER_COL_W 11

// input sample to output pixel, in clocks
// window 1, sums 2, colour select 1
`define DEBAYER_LATENCY 4

`endif

// ==== hdl/video_pkg.sv ====
`include "debayer_consts.svh"

package video_pkg;

    // ------------------------------------------------------------
    // raster stream types
    // ------------------------------------------------------------

    // one raw bayer sample
    typedef logic [`DEBAYER_PIX_W-1:0] pix_t;

    // raster sync levels, all active high
    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } sync_t;

    // output pixel
    // r sits in the low bits, b in the high bits
    typedef struct packed {
        pix_t b;
        pix_t g;
        pix_t r;
    } rgb_t;

endpackage

// ==== hdl/bayer_pkg.sv ====
`include "debayer_consts.svh"

package bayer_pkg;

    // 2x2 cfa layout, named in reading order
    typedef enum logic [1:0] {
        PAT_BGGR = 2'd0,
        PAT_RGGB = 2'd1,
        PAT_GBRG = 2'd2,
        PAT_GRBG = 2'd3
    } pattern_e;

    // parity of the window centre inside the frame
    typedef struct packed {
        logic odd_row;
        logic odd_col;
    } phase_t;

    // 3x3 neighbourhood, raster order, p5 is the centre
    typedef struct packed {
        video_pkg::pix_t p1;
        video_pkg::pix_t p2;
        video_pkg::pix_t p3;
        video_pkg::pix_t p4;
        video_pkg::pix_t p5;
        video_pkg::pix_t p6;
        video_pkg::pix_t p7;
        video_pkg::pix_t p8;
        video_pkg::pix_t p9;
        phase_t          phase;
    } window_t;

    // sum of two samples, sum of four samples
    typedef logic [`DEBAYER_PIX_W:0]   pair_t;
    typedef logic [`DEBAYER_PIX_W+1:0] quad_t;

    typedef struct packed {
        video_pkg::pix_t center;
        pair_t           horiz_sum;
        pair_t           vert_sum;
        quad_t           cross_sum;
        quad_t           corner_sum;
        phase_t          phase;
    } sums_t;

endpackage

// ==== hdl/line_window.sv ====
`include "debayer_consts.svh"

module line_window (
    input  logic               clk,
    input  logic               arst_n_i,
    input  video_pkg::pix_t    pix_i,
    input  video_pkg::sync_t   sync_i,
    output bayer_pkg::window_t win_o,
    output video_pkg::sync_t   sync_o
);
    import video_pkg::*;
    import bayer_pkg::*;

    localparam int ADDR_W = $clog2(`DEBAYER_LINE_MAX);
    localparam int COL_W  = `DEBAYER_COL_W;

    // line y-1 and line y-2
    pix_t line1_mem [`DEBAYER_LINE_MAX];
    pix_t line2_mem [`DEBAYER_LINE_MAX];

    logic [COL_W-1:0]  col_cnt;
    logic [COL_W-1:0]  row_cnt;
    logic              de_q;
    logic [ADDR_W-1:0] addr;
    logic              interior;

    // one shift register per window row, [0] is the newest column
    pix_t [2:0] top_q;
    pix_t [2:0] mid_q;
    pix_t [2:0] bot_q;
    phase_t     phase_q;

    assign addr     = col_cnt[ADDR_W-1:0];
    // centre (x-1, y-1) needs a full column and row on each side
    assign interior = (col_cnt >= COL_W'(2)) && (row_cnt >= COL_W'(2));

    // ------------------------------------------------------------
    // raster position
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_cnt <= '0;
            row_cnt <= '0;
            de_q    <= 1'b0;
        end else begin
            de_q <= sync_i.de;
            if (!sync_i.vs) begin
                // frame gap
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (sync_i.de) begin
                col_cnt <= col_cnt + 1'b1;
            end else if (de_q) begin
                // falling de closes the line
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // line buffers and window
    // ------------------------------------------------------------
    // old line y-1 moves down to y-2 as the new sample comes in
    always_ff @(posedge clk) begin
        if (sync_i.de) begin
            line1_mem[addr] <= pix_i;
            line2_mem[addr] <= line1_mem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (sync_i.de) begin
            top_q           <= {top_q[1:0], line2_mem[addr]};
            mid_q           <= {mid_q[1:0], line1_mem[addr]};
            bot_q           <= {bot_q[1:0], pix_i};
            // centre is one back in both directions, so parity flips
            phase_q.odd_row <= ~row_cnt[0];
            phase_q.odd_col <= ~col_cnt[0];
        end
    end

    // sync, de only for interior centres
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_o <= '0;
        end else begin
            sync_o.de <= sync_i.de && interior;
            sync_o.hs <= sync_i.hs;
            sync_o.vs <= sync_i.vs;
        end
    end

    assign win_o.p1    = top_q[2];
    assign win_o.p2    = top_q[1];
    assign win_o.p3    = top_q[0];
    assign win_o.p4    = mid_q[2];
    assign win_o.p5    = mid_q[1];
    assign win_o.p6    = mid_q[0];
    assign win_o.p7    = bot_q[2];
    assign win_o.p8    = bot_q[1];
    assign win_o.p9    = bot_q[0];
    assign win_o.phase = phase_q;

    // a line longer than the buffers would overwrite live samples
    assert property (@(posedge clk) disable iff (!arst_n_i)
        sync_i.de |-> (col_cnt < COL_W'(`DEBAYER_LINE_MAX)));

endmodule

// ==== hdl/neighbor_sums.sv ====
`include "debayer_consts.svh"

module neighbor_sums (
    input  logic              clk,
    input  logic              arst_n_i,
    input  bayer_pkg::window_t win_i,
    input  video_pkg::sync_t  sync_i,
    output bayer_pkg::sums_t  sums_o,
    output video_pkg::sync_t  sync_o
);
    import video_pkg::*;
    import bayer_pkg::*;

    // stage 1 results
    pair_t  corner_top_q;
    pair_t  corner_bot_q;
    pair_t  vert_q;
    pair_t  horiz_q;
    pix_t   center_q;
    phase_t phase_q;
    sync_t  sync_q;

    // ------------------------------------------------------------
    // stage 1, pair sums
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        // p1 + p3
        corner_top_q <= {1'b0, win_i.p1} + {1'b0, win_i.p3};
        // p7 + p9
        corner_bot_q <= {1'b0, win_i.p7} + {1'b0, win_i.p9};
        // p2 + p8
        vert_q       <= {1'b0, win_i.p2} + {1'b0, win_i.p8};
        // p4 + p6
        horiz_q      <= {1'b0, win_i.p4} + {1'b0, win_i.p6};
        center_q     <= win_i.p5;
        phase_q      <= win_i.phase;
    end

    // ------------------------------------------------------------
    // stage 2, quad sums
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        sums_o.cross_sum  <= {1'b0, vert_q} + {1'b0, horiz_q};
        sums_o.corner_sum <= {1'b0, corner_top_q} + {1'b0, corner_bot_q};
        // pairs still needed at green sites
        sums_o.horiz_sum  <= horiz_q;
        sums_o.vert_sum   <= vert_q;
        sums_o.center     <= center_q;
        sums_o.phase      <= phase_q;
    end

    // sync follows the data, two stages
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
            sync_o <= '0;
        end else begin
            sync_q <= sync_i;
            sync_o <= sync_q;
        end
    end

endmodule

// ==== hdl/color_select.sv ====
`include "debayer_consts.svh"

module color_select (
    input  logic                clk,
    input  logic                arst_n_i,
    input  bayer_pkg::sums_t    sums_i,
    input  video_pkg::sync_t    sync_i,
    input  bayer_pkg::pattern_e mode_i,
    input  logic                bypass_i,
    output video_pkg::rgb_t     rgb_o,
    output video_pkg::sync_t    sync_o
);
    import video_pkg::*;
    import bayer_pkg::*;

    localparam int PIX_W = `DEBAYER_PIX_W;

    // cfa colour at the centre, greens split by the row they sit on
    typedef enum logic [1:0] {
        SITE_R,
        SITE_B,
        SITE_G_RROW,
        SITE_G_BROW
    } site_e;

    logic  r_row;
    logic  r_col;
    logic  row_is_r;
    logic  col_is_r;
    site_e site;
    pix_t  half_h;
    pix_t  half_v;
    pix_t  quart_x;
    pix_t  quart_c;
    rgb_t  rgb_d;

    // ------------------------------------------------------------
    // site decode
    // ------------------------------------------------------------
    // position of R inside the 2x2 tile, B is diagonal to it
    always_comb begin
        case (mode_i)
            PAT_BGGR: begin
                r_row = 1'b1;
                r_col = 1'b1;
            end
            PAT_RGGB: begin
                r_row = 1'b0;
                r_col = 1'b0;
            end
            PAT_GBRG: begin
                r_row = 1'b1;
                r_col = 1'b0;
            end
            default: begin
                r_row = 1'b0;
                r_col = 1'b1;
            end
        endcase
    end

    assign row_is_r = (sums_i.phase.odd_row == r_row);
    assign col_is_r = (sums_i.phase.odd_col == r_col);

    always_comb begin
        case ({row_is_r, col_is_r})
            2'b11:   site = SITE_R;
            2'b00:   site = SITE_B;
            2'b10:   site = SITE_G_RROW;
            default: site = SITE_G_BROW;
        endcase
    end

    // ------------------------------------------------------------
    // channel select
    // ------------------------------------------------------------
    // truncating averages
    assign half_h  = sums_i.horiz_sum[PIX_W:1];
    assign half_v  = sums_i.vert_sum[PIX_W:1];
    assign quart_x = sums_i.cross_sum[PIX_W+1:2];
    assign quart_c = sums_i.corner_sum[PIX_W+1:2];

    always_comb begin
        rgb_d.r = sums_i.center;
        rgb_d.g = sums_i.center;
        rgb_d.b = sums_i.center;
        if (!bypass_i) begin
            case (site)
                SITE_R: begin
                    rgb_d.g = quart_x;
                    rgb_d.b = quart_c;
                end
                SITE_B: begin
                    rgb_d.r = quart_c;
                    rgb_d.g = quart_x;
                end
                SITE_G_RROW: begin
                    rgb_d.r = half_h;
                    rgb_d.b = half_v;
                end
                default: begin
                    rgb_d.r = half_v;
                    rgb_d.b = half_h;
                end
            endcase
        end
    end

    // output holds its last pixel outside de
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rgb_o  <= '0;
            sync_o <= '0;
        end else begin
            sync_o <= sync_i;
            if (sync_i.de) begin
                rgb_o <= rgb_d;
            end
        end
    end

    // every interior window must come from written line buffer words
    assert property (@(posedge clk) disable iff (!arst_n_i)
        sync_o.de |-> !$isunknown(rgb_o));

endmodule

// ==== hdl/debayer_top.sv ====
`include "debayer_consts.svh"

module debayer_top (
    input  logic                clk,
    input  logic                arst_n_i,
    input  bayer_pkg::pattern_e mode_i,
    input  logic                bypass_i,
    input  video_pkg::pix_t     pix_i,
    input  logic                de_i,
    input  logic                hs_i,
    input  logic                vs_i,
    output video_pkg::rgb_t     rgb_o,
    output logic                de_o,
    output logic                hs_o,
    output logic                vs_o
);
    import video_pkg::*;
    import bayer_pkg::*;

    sync_t   sync_in;
    sync_t   sync_win;
    sync_t   sync_sum;
    sync_t   sync_out;
    window_t win;
    sums_t   sums;

    assign sync_in.de = de_i;
    assign sync_in.hs = hs_i;
    assign sync_in.vs = vs_i;

    // ------------------------------------------------------------
    // window -> sums -> colour
    // ------------------------------------------------------------
    line_window line_window_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .pix_i    (pix_i),
        .sync_i   (sync_in),
        .win_o    (win),
        .sync_o   (sync_win)
    );

    neighbor_sums neighbor_sums_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .win_i    (win),
        .sync_i   (sync_win),
        .sums_o   (sums),
        .sync_o   (sync_sum)
    );

    color_select color_select_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .sums_i   (sums),
        .sync_i   (sync_sum),
        .mode_i   (mode_i),
        .bypass_i (bypass_i),
        .rgb_o    (rgb_o),
        .sync_o   (sync_out)
    );

    assign de_o = sync_out.de;
    assign hs_o = sync_out.hs;
    assign vs_o = sync_out.vs;

    // hs and vs pass all three stages unchanged
    assert property (@(posedge clk) disable iff (!arst_n_i)
        {hs_o, vs_o} == $past({hs_i, vs_i}, `DEBAYER_LATENCY));

endmodule

// ==== verif/tb_debayer.sv ====
`include "debayer_consts.svh"

module tb_debayer;
    import video_pkg::*;
    import bayer_pkg::*;

    localparam int LAT = `DEBAYER_LATENCY;

    logic     clk;
    logic     arst_n_i;
    pattern_e mode_i;
    logic     bypass_i;
    pix_t     pix_i;
    logic     de_i;
    logic     hs_i;
    logic     vs_i;
    rgb_t     rgb_o;
    logic     de_o;
    logic     hs_o;
    logic     vs_o;

    // expected interior de, driven next to de_i
    logic     win_de;

    // frame table, one entry per test frame
    string    tab_name [$];
    int       tab_w    [$];
    int       tab_h    [$];
    pattern_e tab_mode [$];
    logic     tab_byp  [$];
    int       tab_flat [$];
    int       pend_q   [$];
    logic     table_ready = 1'b0;

    pix_t        frame [16][16];
    int unsigned seed;
    int          frames_done = 0;

    // monitor state
    sync_t hist [LAT];
    sync_t act_s;
    rgb_t  exp_px;
    logic  vs_prev = 1'b0;
    int    mon_idx;
    int    pix_cnt;
    int    cx;
    int    cy;

    debayer_top debayer_top_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .mode_i   (mode_i),
        .bypass_i (bypass_i),
        .pix_i    (pix_i),
        .de_i     (de_i),
        .hs_i     (hs_i),
        .vs_i     (vs_i),
        .rgb_o    (rgb_o),
        .de_o     (de_o),
        .hs_o     (hs_o),
        .vs_o     (vs_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // cfa letter at frame parity (r, c), tile read left to right, top to bottom
    function automatic byte site_letter(pattern_e p, int r, int c);
        string tile;
        case (p)
            PAT_BGGR: tile = "BGGR";
            PAT_RGGB: tile = "RGGB";
            PAT_GBRG: tile = "GBRG";
            default:  tile = "GRBG";
        endcase
        return tile[r * 2 + c];
    endfunction

    function automatic rgb_t ref_pixel(int x, int y, pattern_e p, logic byp);
        int   c;
        int   hsum;
        int   vsum;
        int   xsum;
        int   csum;
        byte  s;
        rgb_t px;
        c    = int'(frame[y][x]);
        hsum = int'(frame[y][x-1]) + int'(frame[y][x+1]);
        vsum = int'(frame[y-1][x]) + int'(frame[y+1][x]);
        xsum = hsum + vsum;
        csum = int'(frame[y-1][x-1]) + int'(frame[y-1][x+1])
             + int'(frame[y+1][x-1]) + int'(frame[y+1][x+1]);
        s    = site_letter(p, y % 2, x % 2);
        px.r = pix_t'(c);
        px.g = pix_t'(c);
        px.b = pix_t'(c);
        if (!byp) begin
            if (s == "R") begin
                px.g = pix_t'(xsum / 4);
                px.b = pix_t'(csum / 4);
            end else if (s == "B") begin
                px.g = pix_t'(xsum / 4);
                px.r = pix_t'(csum / 4);
            end else if (site_letter(p, y % 2, (x + 1) % 2) == "R") begin
                // green on a red row
                px.r = pix_t'(hsum / 2);
                px.b = pix_t'(vsum / 2);
            end else begin
                px.b = pix_t'(hsum / 2);
                px.r = pix_t'(vsum / 2);
            end
        end
        return px;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_rgb(string name, rgb_t exp_v, rgb_t act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %h actual %h", name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "rgb mismatch");
        end
    endtask

    task automatic check_sync(string name, sync_t exp_v, sync_t act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected %b actual %b", name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "sync mismatch");
        end
    endtask

    task automatic check_count(string name, int exp_v, int act_v);
        if (act_v != exp_v) begin
            $display("Error: %s expected %0d actual %0d", name, exp_v, act_v);
            $display("TESTS FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    // sync levels lag by LAT, pixels walk the interior in raster order
    always @(posedge clk) begin
        if (arst_n_i) begin
            act_s.de = de_o;
            act_s.hs = hs_o;
            act_s.vs = vs_o;
            check_sync("sync latency", hist[LAT-1], act_s);
            if (vs_o && !vs_prev) begin
                if (pend_q.size() == 0) begin
                    $display("vs_o rose although no frame was sent");
                    $display("TESTS FAILED");
                    $fatal(1, "unexpected frame");
                end
                mon_idx = pend_q.pop_front();
                pix_cnt = 0;
                cx      = 0;
                cy      = 0;
            end
            if (de_o) begin
                exp_px = ref_pixel(cx + 1, cy + 1, tab_mode[mon_idx], tab_byp[mon_idx]);
                check_rgb(tab_name[mon_idx], exp_px, rgb_o);
                pix_cnt++;
                cx++;
                if (cx == tab_w[mon_idx] - 2) begin
                    cx = 0;
                    cy++;
                end
            end
            if (!vs_o && vs_prev) begin
                check_count(tab_name[mon_idx],
                            (tab_w[mon_idx] - 2) * (tab_h[mon_idx] - 2), pix_cnt);
                frames_done++;
            end
            vs_prev = vs_o;
        end
        for (int i = LAT - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = {win_de, hs_i, vs_i};
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic add_frame(string name, int w, int h, pattern_e p, logic byp, int flat);
        tab_name.push_back(name);
        tab_w.push_back(w);
        tab_h.push_back(h);
        tab_mode.push_back(p);
        tab_byp.push_back(byp);
        // negative flat means random samples
        tab_flat.push_back(flat);
    endtask

    task automatic drive_cycle(logic de, logic hs, logic vs, pix_t pix, logic win);
        @(posedge clk);
        de_i   <= de;
        hs_i   <= hs;
        vs_i   <= vs;
        pix_i  <= pix;
        win_de <= win;
    endtask

    task automatic send_frame(int idx);
        pix_t pix;
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
        // mode changes late in the gap, after the last pixel left color_select
        mode_i   <= tab_mode[idx];
        bypass_i <= tab_byp[idx];
        pend_q.push_back(idx);
        for (int y = 0; y < tab_h[idx]; y++) begin
            for (int x = 0; x < tab_w[idx]; x++) begin
                if (tab_flat[idx] >= 0) begin
                    pix = pix_t'(tab_flat[idx]);
                end else begin
                    seed = lcg_next(seed);
                    pix  = seed[`DEBAYER_PIX_W+15:16];
                end
                frame[y][x] = pix;
                drive_cycle(1'b1, 1'b0, 1'b1, pix, (x >= 2) && (y >= 2));
            end
            // line blank, hs pulse on the first cycle
            drive_cycle(1'b0, 1'b1, 1'b1, '0, 1'b0);
            drive_cycle(1'b0, 1'b0, 1'b1, '0, 1'b0);
        end
    endtask

    function automatic int total_cycles();
        int n;
        n = 2 + 12;
        foreach (tab_w[i]) begin
            n += 4 + tab_h[i] * (tab_w[i] + 2);
        end
        return n;
    endfunction

    initial begin
        arst_n_i <= 1'b0;
        mode_i   <= PAT_BGGR;
        bypass_i <= 1'b0;
        pix_i    <= '0;
        de_i     <= 1'b0;
        hs_i     <= 1'b0;
        vs_i     <= 1'b0;
        win_de   <= 1'b0;
        // nothing in flight before the first edge
        foreach (hist[i]) begin
            hist[i] = '0;
        end
        seed     = 32'd59888;
        add_frame("pattern bggr", 10, 8, PAT_BGGR, 1'b0, -1);
        add_frame("pattern rggb", 10, 8, PAT_RGGB, 1'b0, -1);
        add_frame("pattern gbrg", 10, 8, PAT_GBRG, 1'b0, -1);
        add_frame("pattern grbg", 10, 8, PAT_GRBG, 1'b0, -1);
        add_frame("bypass", 10, 8, PAT_GRBG, 1'b1, -1);
        add_frame("wide frame", 14, 6, PAT_RGGB, 1'b0, -1);
        add_frame("narrow frame", 6, 5, PAT_BGGR, 1'b0, -1);
        add_frame("flat bggr", 9, 7, PAT_BGGR, 1'b0, 8'hc3);
        add_frame("flat rggb", 9, 7, PAT_RGGB, 1'b0, 8'h5a);
        add_frame("flat gbrg", 9, 7, PAT_GBRG, 1'b0, 8'hff);
        add_frame("flat grbg", 9, 7, PAT_GRBG, 1'b0, 8'h01);
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        for (int i = 0; i < tab_w.size(); i++) begin
            send_frame(i);
        end
        // flush the last frame through the pipeline
        repeat (12) drive_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
        check_count("frames completed", tab_w.size(), frames_done);
        $display("TESTS PASSED");
        $finish;
    end

    // watchdog sized from the frame table
    initial begin
        longint limit;
        wait (table_ready);
        limit = (longint'(total_cycles()) + 40) * 100;
        #(limit);
        $display("Watchdog expired after %0d time units, the run did not finish", limit);
        $display("TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/bayer_pkg.sv
hdl/line_window.sv
hdl/neighbor_sums.sv
hdl/color_select.sv
hdl/debayer_top.sv
verif/tb_debayer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the debayer testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_debayer \
    -f build.f > build.log 2>&1 \
    && ./obj_dir/Vtb_debayer > sim.log 2>&1

grep -qx "TESTS PASSED" sim.log \
    && echo "simulation ok, see sim.log" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
